// File: source/icache_pkg.sv
// Shared cache geometry, address fields and refill states; imported by every cache module
package icache_pkg;

	// ==============================
	// Address and line geometry
	// ==============================

	// Byte address width
	localparam int ADDR_W = 32;
	// One line is four 32-bit words
	localparam int LINE_W = 128;
	localparam int LINE_BYTES = LINE_W / 8;
	// Byte offset inside a line
	localparam int OFFS_W = 4;

	// Even/odd line select, first bit above the offset
	localparam int BANK_BIT = OFFS_W;

	// Sets per bank and set index field
	localparam int SETS = 16;
	localparam int SET_W = 4;
	localparam int SET_LSB = BANK_BIT + 1;

	// Ways per bank
	localparam int WAYS = 2;
	localparam int WAY_W = 1;

	// Tag is everything above the set index
	localparam int TAG_LSB = SET_LSB + SET_W;
	localparam int TAG_W = ADDR_W - TAG_LSB;

	// ==============================
	// Fill pattern and refill control
	// ==============================

	// Returned for every byte of a line that missed
	localparam logic [7:0] NOP_BYTE = 8'hFF;

	// Cycles spent draining the lookup pipeline after a line write
	localparam int SETTLE_CYCLES = 2;

	// Refill engine states
	typedef enum logic [1:0] {
		FILL_IDLE,
		FILL_REQ,
		FILL_WRITE,
		FILL_SETTLE
	} fill_state_t;

endpackage

// File: source/icache_bank.sv
// One cache bank of tags, valid bits, line data and round-robin state; instantiated per even/odd bank
module icache_bank
	import icache_pkg::*;
(
	input  logic              clk,
	input  logic              rst,
	input  logic              ce_i,
	// Lookup side
	input  logic [SET_W-1:0]  rd_set_i,
	input  logic [TAG_W-1:0]  rd_tag_i,
	// Refill write side
	input  logic              wr_i,
	input  logic [SET_W-1:0]  wr_set_i,
	input  logic [TAG_W-1:0]  wr_tag_i,
	input  logic [LINE_W-1:0] wr_data_i,
	// Invalidation
	input  logic              inv_all_i,
	input  logic              inv_line_i,
	input  logic [SET_W-1:0]  inv_set_i,
	input  logic [TAG_W-1:0]  inv_tag_i,
	// Registered lookup result
	output logic              hit_o,
	output logic [LINE_W-1:0] data_o
);

	// ==============================
	// Storage
	// ==============================

	logic [TAG_W-1:0]  tag_mem  [WAYS][SETS];
	logic [LINE_W-1:0] data_mem [WAYS][SETS];
	logic [SETS-1:0]   valid_q  [WAYS];
	// Next way to replace, one per set
	logic [WAY_W-1:0]  rr_ptr_q [SETS];

	logic [WAYS-1:0]   way_hit;
	logic [LINE_W-1:0] hit_data;
	logic [WAY_W-1:0]  wr_way;

	// Victim way for the set being written
	assign wr_way = rr_ptr_q[wr_set_i];

	// ==============================
	// Hit compare
	// ==============================

	// Default to the NOP line, replaced by the matching way
	always_comb begin
		hit_data = {LINE_BYTES{NOP_BYTE}};
		for (int w = 0; w < WAYS; w++) begin
			way_hit[w] = valid_q[w][rd_set_i] && (tag_mem[w][rd_set_i] == rd_tag_i);
			if (way_hit[w])
				hit_data = data_mem[w][rd_set_i];
		end
	end

	// Hit flag is control state and clears on reset
	always_ff @(posedge clk) begin
		if (rst)
			hit_o <= 1'b0;
		else if (ce_i)
			hit_o <= |way_hit;
	end

	// Line data only moves with the pipeline
	always_ff @(posedge clk) begin
		if (ce_i)
			data_o <= hit_data;
	end

	// ==============================
	// Line write
	// ==============================

	// Tag and data arrays
	always_ff @(posedge clk) begin
		if (wr_i) begin
			tag_mem[wr_way][wr_set_i] <= wr_tag_i;
			data_mem[wr_way][wr_set_i] <= wr_data_i;
		end
	end

	// Valid bits and replacement pointers
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int w = 0; w < WAYS; w++)
				valid_q[w] <= '0;
			for (int s = 0; s < SETS; s++)
				rr_ptr_q[s] <= '0;
		end else begin
			if (wr_i) begin
				valid_q[wr_way][wr_set_i] <= 1'b1;
				// Round robin, wraps at WAYS
				rr_ptr_q[wr_set_i] <= wr_way + 1'b1;
			end
			// Invalidation wins over a write in the same cycle
			if (inv_all_i) begin
				for (int w = 0; w < WAYS; w++)
					valid_q[w] <= '0;
			end else if (inv_line_i) begin
				for (int w = 0; w < WAYS; w++) begin
					if (tag_mem[w][inv_set_i] == inv_tag_i)
						valid_q[w][inv_set_i] <= 1'b0;
				end
			end
		end
	end

	// ==============================
	// Checks
	// ==============================

	// No set may hold one line twice
	for (genvar s = 0; s < SETS; s++) begin : g_chk_set
		for (genvar a = 0; a < WAYS; a++) begin : g_chk_a
			for (genvar b = a + 1; b < WAYS; b++) begin : g_chk_b
				a_tag_unique: assert property (@(posedge clk) disable iff (rst)
					!(valid_q[a][s] && valid_q[b][s] && tag_mem[a][s] == tag_mem[b][s]))
					else $error("Duplicate valid tag in set %0d", s);
			end
		end
	end

endmodule

// File: source/icache.sv
// Two-bank instruction cache returning the lo/hi line pair for a fetch address; used under icache_top
module icache
	import icache_pkg::*;
(
	input  logic              clk,
	input  logic              rst,
	input  logic              ce_i,
	input  logic [ADDR_W-1:0] ip_i,
	// Invalidation requests
	input  logic              inv_all_i,
	input  logic              inv_line_i,
	input  logic [ADDR_W-1:0] inv_adr_i,
	// Line write from the refill engine
	input  logic              wr_ic_i,
	input  logic [ADDR_W-1:0] wr_adr_i,
	input  logic [LINE_W-1:0] wr_data_i,
	// Lookup result, one cycle after sampling
	output logic [ADDR_W-1:0] ip_o,
	output logic              ihit_o,
	output logic [LINE_W-1:0] line_lo_o,
	output logic [LINE_W-1:0] line_hi_o,
	// Miss report
	output logic              miss_v_o,
	output logic [ADDR_W-1:0] miss_adr_o
);

	// Line pair index, address bits above the bank bit
	localparam int PAIR_W = ADDR_W - SET_LSB;

	logic [PAIR_W-1:0] pair_idx;
	logic [PAIR_W-1:0] even_idx;
	logic [PAIR_W-1:0] even_idx_q;
	logic              lookup_v_q;
	logic              line_odd;

	logic              hit_even;
	logic              hit_odd;
	logic [LINE_W-1:0] data_even;
	logic [LINE_W-1:0] data_odd;

	logic              wr_even;
	logic              wr_odd;
	logic              inv_even;
	logic              inv_odd;

	// ==============================
	// Read index
	// ==============================

	// Odd bank reads the pair containing ip_i
	assign pair_idx = ip_i[ADDR_W-1:SET_LSB];
	// In an odd line the next even line lives in the next pair
	// Carry runs on into the tag
	assign even_idx = pair_idx + PAIR_W'(ip_i[BANK_BIT]);

	// ==============================
	// Fetch pipeline register
	// ==============================

	always_ff @(posedge clk) begin
		if (rst) begin
			ip_o <= '0;
			lookup_v_q <= 1'b0;
		end else if (ce_i) begin
			ip_o <= ip_i;
			lookup_v_q <= 1'b1;
		end
	end

	// Even line index of the sampled fetch, for the miss address
	always_ff @(posedge clk) begin
		if (ce_i)
			even_idx_q <= even_idx;
	end

	// ==============================
	// Write and invalidate decode
	// ==============================

	// Bank picked by the line parity of the address
	assign wr_even = wr_ic_i & ~wr_adr_i[BANK_BIT];
	assign wr_odd = wr_ic_i & wr_adr_i[BANK_BIT];
	assign inv_even = inv_line_i & ~inv_adr_i[BANK_BIT];
	assign inv_odd = inv_line_i & inv_adr_i[BANK_BIT];

	icache_bank u_bank_even (
		.clk        (clk),
		.rst        (rst),
		.ce_i       (ce_i),
		.rd_set_i   (even_idx[SET_W-1:0]),
		.rd_tag_i   (even_idx[PAIR_W-1:SET_W]),
		.wr_i       (wr_even),
		.wr_set_i   (wr_adr_i[TAG_LSB-1:SET_LSB]),
		.wr_tag_i   (wr_adr_i[ADDR_W-1:TAG_LSB]),
		.wr_data_i  (wr_data_i),
		.inv_all_i  (inv_all_i),
		.inv_line_i (inv_even),
		.inv_set_i  (inv_adr_i[TAG_LSB-1:SET_LSB]),
		.inv_tag_i  (inv_adr_i[ADDR_W-1:TAG_LSB]),
		.hit_o      (hit_even),
		.data_o     (data_even)
	);

	icache_bank u_bank_odd (
		.clk        (clk),
		.rst        (rst),
		.ce_i       (ce_i),
		.rd_set_i   (pair_idx[SET_W-1:0]),
		.rd_tag_i   (pair_idx[PAIR_W-1:SET_W]),
		.wr_i       (wr_odd),
		.wr_set_i   (wr_adr_i[TAG_LSB-1:SET_LSB]),
		.wr_tag_i   (wr_adr_i[ADDR_W-1:TAG_LSB]),
		.wr_data_i  (wr_data_i),
		.inv_all_i  (inv_all_i),
		.inv_line_i (inv_odd),
		.inv_set_i  (inv_adr_i[TAG_LSB-1:SET_LSB]),
		.inv_tag_i  (inv_adr_i[ADDR_W-1:TAG_LSB]),
		.hit_o      (hit_odd),
		.data_o     (data_odd)
	);

	// ==============================
	// Line swap and hit
	// ==============================

	// Parity of the line holding ip_o
	assign line_odd = ip_o[BANK_BIT];

	// lo holds ip_o, hi is the following line
	assign line_lo_o = line_odd ? data_odd : data_even;
	assign line_hi_o = line_odd ? data_even : data_odd;

	// Both halves must be present
	assign ihit_o = hit_even & hit_odd;

	// ==============================
	// Miss report
	// ==============================

	// Quiet until the first lookup after reset
	assign miss_v_o = lookup_v_q & ~(hit_even & hit_odd);

	// Even line first, then the odd one
	assign miss_adr_o = !hit_even ? {even_idx_q, 1'b0, {OFFS_W{1'b0}}}
		: {ip_o[ADDR_W-1:SET_LSB], 1'b1, {OFFS_W{1'b0}}};

	// Refill writes whole lines only
	a_wr_aligned: assert property (@(posedge clk) disable iff (rst)
		wr_ic_i |-> wr_adr_i[OFFS_W-1:0] == '0)
		else $error("Line write with unaligned address %h", wr_adr_i);

endmodule

// File: source/icache_fill.sv
// Refill engine that fetches a missing line from memory and writes it into the cache
module icache_fill
	import icache_pkg::*;
(
	input  logic              clk,
	input  logic              rst,
	// Miss report from the cache
	input  logic              miss_v_i,
	input  logic [ADDR_W-1:0] miss_adr_i,
	// Memory port
	input  logic              mem_ack_i,
	input  logic [LINE_W-1:0] mem_data_i,
	output logic              mem_req_o,
	output logic [ADDR_W-1:0] mem_adr_o,
	// Line write into the cache
	output logic              wr_ic_o,
	output logic [ADDR_W-1:0] wr_adr_o,
	output logic [LINE_W-1:0] wr_data_o
);

	fill_state_t       state_q;
	logic [1:0]        settle_q;
	logic [ADDR_W-1:0] adr_q;
	logic [LINE_W-1:0] line_q;

	// ==============================
	// State machine
	// ==============================

	always_ff @(posedge clk) begin
		if (rst) begin
			state_q <= FILL_IDLE;
			settle_q <= '0;
		end else begin
			case (state_q)
				FILL_IDLE: begin
					if (miss_v_i)
						state_q <= FILL_REQ;
				end
				// Held here for as long as memory takes
				FILL_REQ: begin
					if (mem_ack_i)
						state_q <= FILL_WRITE;
				end
				// One write cycle
				FILL_WRITE: begin
					state_q <= FILL_SETTLE;
					settle_q <= '0;
				end
				// Let the stale miss pass through the lookup register
				FILL_SETTLE: begin
					if (settle_q == 2'(SETTLE_CYCLES - 1))
						state_q <= FILL_IDLE;
					else
						settle_q <= settle_q + 1'b1;
				end
				default: state_q <= FILL_IDLE;
			endcase
		end
	end

	// ==============================
	// Address and line capture
	// ==============================

	always_ff @(posedge clk) begin
		// Miss address is already line aligned
		if (state_q == FILL_IDLE && miss_v_i)
			adr_q <= miss_adr_i;
		// Data comes with the acknowledge
		if (state_q == FILL_REQ && mem_ack_i)
			line_q <= mem_data_i;
	end

	// Memory request held until acknowledge
	assign mem_req_o = (state_q == FILL_REQ);
	assign mem_adr_o = adr_q;

	// Cache write
	assign wr_ic_o = (state_q == FILL_WRITE);
	assign wr_adr_o = adr_q;
	assign wr_data_o = line_q;

	// ==============================
	// Checks
	// ==============================

	// Request and address stay put until acknowledged
	a_req_hold: assert property (@(posedge clk) disable iff (rst)
		mem_req_o && !mem_ack_i |=> mem_req_o && $stable(mem_adr_o))
		else $error("Memory request dropped before acknowledge");

	// Memory only acknowledges an outstanding request
	a_ack_in_req: assert property (@(posedge clk) disable iff (rst)
		mem_ack_i |-> mem_req_o)
		else $error("Memory acknowledge without a pending request");

endmodule

// File: source/icache_top.sv
// Instruction cache front end joining the two-bank cache and its refill engine
module icache_top
	import icache_pkg::*;
(
	input  logic              clk,
	input  logic              rst,
	// Core side
	input  logic              ce_i,
	input  logic [ADDR_W-1:0] ip_i,
	input  logic              inv_all_i,
	input  logic              inv_line_i,
	input  logic [ADDR_W-1:0] inv_adr_i,
	output logic [ADDR_W-1:0] ip_o,
	output logic              ihit_o,
	output logic [LINE_W-1:0] line_lo_o,
	output logic [LINE_W-1:0] line_hi_o,
	// Memory side
	output logic              mem_req_o,
	output logic [ADDR_W-1:0] mem_adr_o,
	input  logic              mem_ack_i,
	input  logic [LINE_W-1:0] mem_data_i
);

	// Miss report, cache to refill
	logic              miss_v;
	logic [ADDR_W-1:0] miss_adr;
	// Line write, refill to cache
	logic              wr_ic;
	logic [ADDR_W-1:0] wr_adr;
	logic [LINE_W-1:0] wr_data;

	icache u_icache (
		.clk        (clk),
		.rst        (rst),
		.ce_i       (ce_i),
		.ip_i       (ip_i),
		.inv_all_i  (inv_all_i),
		.inv_line_i (inv_line_i),
		.inv_adr_i  (inv_adr_i),
		.wr_ic_i    (wr_ic),
		.wr_adr_i   (wr_adr),
		.wr_data_i  (wr_data),
		.ip_o       (ip_o),
		.ihit_o     (ihit_o),
		.line_lo_o  (line_lo_o),
		.line_hi_o  (line_hi_o),
		.miss_v_o   (miss_v),
		.miss_adr_o (miss_adr)
	);

	icache_fill u_icache_fill (
		.clk        (clk),
		.rst        (rst),
		.miss_v_i   (miss_v),
		.miss_adr_i (miss_adr),
		.mem_ack_i  (mem_ack_i),
		.mem_data_i (mem_data_i),
		.mem_req_o  (mem_req_o),
		.mem_adr_o  (mem_adr_o),
		.wr_ic_o    (wr_ic),
		.wr_adr_o   (wr_adr),
		.wr_data_o  (wr_data)
	);

endmodule

// File: test/tb_icache.sv
// Self-checking testbench for the instruction cache front end, driven by test/icache_input.txt
module tb_icache
	import icache_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	// ==============================
	// Constants
	// ==============================

	localparam int CLK_PERIOD = 100;
	localparam int RESET_CYCLES = 2;
	localparam logic [31:0] SEED = 32'h1e4;
	// Memory word is its own address scrambled with this key
	localparam logic [31:0] MEM_KEY = 32'h5a3c_96e1;
	// Budget for the slowest command which is a fetch with two refills
	localparam int CYCLES_PER_CMD = 40;
	localparam string INPUT_FILE = "test/icache_input.txt";

	// ==============================
	// DUT signals
	// ==============================

	logic              clk;
	logic              rst;
	logic              ce_i;
	logic [ADDR_W-1:0] ip_i;
	logic              inv_all_i;
	logic              inv_line_i;
	logic [ADDR_W-1:0] inv_adr_i;
	logic [ADDR_W-1:0] ip_o;
	logic              ihit_o;
	logic [LINE_W-1:0] line_lo_o;
	logic [LINE_W-1:0] line_hi_o;
	logic              mem_req_o;
	logic [ADDR_W-1:0] mem_adr_o;
	logic              mem_ack_i;
	logic [LINE_W-1:0] mem_data_i;

	// Commands from the data file
	logic [7:0]        cmd_q [$];
	logic [ADDR_W-1:0] adr_q [$];
	logic              exp_q [$];
	int                watchdog_cycles = 0;

	// Every byte of a line that missed
	localparam logic [LINE_W-1:0] NOP_LINE = {(LINE_W / 8){NOP_BYTE}};

	icache_top UUT (
		.clk        (clk),
		.rst        (rst),
		.ce_i       (ce_i),
		.ip_i       (ip_i),
		.inv_all_i  (inv_all_i),
		.inv_line_i (inv_line_i),
		.inv_adr_i  (inv_adr_i),
		.ip_o       (ip_o),
		.ihit_o     (ihit_o),
		.line_lo_o  (line_lo_o),
		.line_hi_o  (line_hi_o),
		.mem_req_o  (mem_req_o),
		.mem_adr_o  (mem_adr_o),
		.mem_ack_i  (mem_ack_i),
		.mem_data_i (mem_data_i)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// ==============================
	// Helpers
	// ==============================

	// Line content held by memory with word 0 in the low bits
	function automatic logic [LINE_W-1:0] model_line(input logic [ADDR_W-1:0] adr);
		logic [LINE_W-1:0] data;
		logic [ADDR_W-1:0] base;
		base = {adr[ADDR_W-1:OFFS_W], {OFFS_W{1'b0}}};
		for (int i = 0; i < LINE_W / 32; i++)
			data[32*i +: 32] = (base + ADDR_W'(4 * i)) ^ MEM_KEY;
		return data;
	endfunction

	task automatic check(input string name, input logic [LINE_W-1:0] actual,
			input logic [LINE_W-1:0] expected);
		if (actual !== expected) begin
			$display("CHECK FAILED %s: got %h, expected %h", name, actual, expected);
			$display("Verification failed");
			$fatal(1);
		end
	endtask

	task automatic load_commands();
		int fd;
		int n;
		string text;
		logic [7:0] cmd;
		logic [ADDR_W-1:0] adr;
		logic [31:0] exp_hit;
		fd = $fopen(INPUT_FILE, "r");
		if (fd == 0) begin
			$display("Could not open the command file %s", INPUT_FILE);
			$display("Verification failed");
			$fatal(1);
		end
		while ($fgets(text, fd) != 0) begin
			// Comment and blank lines
			if (text.len() < 2 || text[0] == "#")
				continue;
			n = $sscanf(text, "%c %h %h", cmd, adr, exp_hit);
			if (n != 3 || !(cmd inside {"F", "A", "L"})) begin
				$display("Unreadable line in the command file: %s", text);
				$display("Verification failed");
				$fatal(1);
			end
			cmd_q.push_back(cmd);
			adr_q.push_back(adr);
			exp_q.push_back(exp_hit[0]);
		end
		$fclose(fd);
		if (cmd_q.size() == 0) begin
			$display("The command file holds no commands");
			$display("Verification failed");
			$fatal(1);
		end
	endtask

	// ==============================
	// Core side
	// ==============================

	task automatic fetch(input logic [ADDR_W-1:0] adr, input logic exp_hit);
		logic [ADDR_W-1:0] lo_adr;
		logic [LINE_W-1:0] lo_exp;
		logic [LINE_W-1:0] hi_exp;
		logic              lo_ok;
		logic              hi_ok;
		lo_adr = {adr[ADDR_W-1:OFFS_W], {OFFS_W{1'b0}}};
		lo_exp = model_line(lo_adr);
		hi_exp = model_line(lo_adr + ADDR_W'(LINE_W / 8));
		@(posedge clk);
		ce_i <= 1'b1;
		ip_i <= adr;
		// Sampled at the next edge with the result after it
		@(posedge clk);
		@(negedge clk);
		check("ip_o", LINE_W'(ip_o), LINE_W'(adr));
		check("ihit_o", LINE_W'(ihit_o), LINE_W'(exp_hit));
		if (!ihit_o) begin
			lo_ok = (line_lo_o === lo_exp);
			hi_ok = (line_hi_o === hi_exp);
			// A line is either cached data or the NOP fill
			if (!lo_ok)
				check("line_lo_o", line_lo_o, NOP_LINE);
			if (!hi_ok)
				check("line_hi_o", line_hi_o, NOP_LINE);
			check("missing line count", LINE_W'(lo_ok & hi_ok), '0);
		end
		// ip_i held while refill runs
		while (!ihit_o)
			@(negedge clk);
		check("ip_o", LINE_W'(ip_o), LINE_W'(adr));
		check("line_lo_o", line_lo_o, lo_exp);
		check("line_hi_o", line_hi_o, hi_exp);
	endtask

	// Drop ce_i with a new address and check that the outputs hold
	task automatic stall_hold();
		int                idle;
		logic [ADDR_W-1:0] ip_hold;
		logic              hit_hold;
		logic [LINE_W-1:0] lo_hold;
		logic [LINE_W-1:0] hi_hold;
		idle = int'($urandom_range(3, 1));
		@(posedge clk);
		ce_i <= 1'b0;
		ip_i <= $urandom();
		// Last lookup with ce_i high lands here
		@(negedge clk);
		ip_hold = ip_o;
		hit_hold = ihit_o;
		lo_hold = line_lo_o;
		hi_hold = line_hi_o;
		repeat (idle) begin
			@(negedge clk);
			check("ip_o", LINE_W'(ip_o), LINE_W'(ip_hold));
			check("ihit_o", LINE_W'(ihit_o), LINE_W'(hit_hold));
			check("line_lo_o", line_lo_o, lo_hold);
			check("line_hi_o", line_hi_o, hi_hold);
		end
	endtask

	task automatic invalidate_all();
		@(posedge clk);
		inv_all_i <= 1'b1;
		@(posedge clk);
		inv_all_i <= 1'b0;
	endtask

	task automatic invalidate_line(input logic [ADDR_W-1:0] adr);
		@(posedge clk);
		inv_line_i <= 1'b1;
		inv_adr_i <= adr;
		@(posedge clk);
		inv_line_i <= 1'b0;
	endtask

	// ==============================
	// Memory model and watchdog
	// ==============================

	// Acknowledge after 1 to 4 cycles with the data alongside
	initial begin : memory_model
		int unsigned       delay;
		logic [ADDR_W-1:0] req_adr;
		forever begin
			@(negedge clk);
			if (mem_req_o === 1'b1) begin
				req_adr = mem_adr_o;
				// Refill asks for whole lines
				check("mem_adr_o offset", LINE_W'(req_adr[OFFS_W-1:0]), '0);
				delay = $urandom_range(4, 1);
				repeat (delay) @(posedge clk);
				mem_ack_i <= 1'b1;
				mem_data_i <= model_line(req_adr);
				// Request and address still held in the acknowledge cycle
				@(negedge clk);
				check("mem_req_o", LINE_W'(mem_req_o), LINE_W'(1'b1));
				check("mem_adr_o", LINE_W'(mem_adr_o), LINE_W'(req_adr));
				@(posedge clk);
				mem_ack_i <= 1'b0;
			end
		end
	end

	initial begin : watchdog
		wait (watchdog_cycles != 0);
		repeat (watchdog_cycles) @(posedge clk);
		$display("Timeout: the run did not finish within %0d clock cycles", watchdog_cycles);
		$display("Verification failed");
		$fatal(1);
	end

	// ==============================
	// Main sequence
	// ==============================

	initial begin : main
		rst = 1'b1;
		ce_i = 1'b0;
		ip_i = '0;
		inv_all_i = 1'b0;
		inv_line_i = 1'b0;
		inv_adr_i = '0;
		mem_ack_i = 1'b0;
		mem_data_i = '0;
		void'($urandom(SEED));
		load_commands();
		watchdog_cycles = cmd_q.size() * CYCLES_PER_CMD + RESET_CYCLES + 10;
		repeat (RESET_CYCLES) @(posedge clk);
		rst <= 1'b0;
		for (int i = 0; i < cmd_q.size(); i++) begin
			case (cmd_q[i])
				"F": begin
					fetch(adr_q[i], exp_q[i]);
					stall_hold();
				end
				"A": invalidate_all();
				default: invalidate_line(adr_q[i]);
			endcase
		end
		$display("Verification passed");
		$finish;
	end

endmodule

// File: test/icache_input.txt
# Columns: command (F fetch, A invalidate all, L invalidate line), address in hex,
# expected ihit_o of the first lookup (unused by A and L)
F 00001000 0
F 00001008 1
F 0000101c 0
F 00001014 1
F 00001000 1
F 00002000 0
F 00001004 1
F 00003000 0
F 00001000 0
F 00003008 1
F 00002000 0
F 00001000 1
L 00001010 0
F 00002004 1
F 0000101c 0
F 00001000 1
L 00001020 0
F 00001000 1
F 00001014 0
A 00000000 0
F 00001000 0
F 00002000 0
F 00001014 0
F 00001008 1
F 000011f8 0
F 000011f4 1
F 00001000 0
F 00002000 0

// File: vlog.f
source/icache_pkg.sv
source/icache_bank.sv
source/icache.sv
source/icache_fill.sv
source/icache_top.sv
test/tb_icache.sv

// File: Makefile
# Verilator build and run of the instruction cache testbench

VERILATOR ?= verilator
TOP       ?= tb_icache
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
